//--- logic/align_pkg.sv
package align_pkg;

  localparam int WIDTH      = 32;
  localparam int NUMADDR    = 1000;
  localparam int BITADDR    = 10;
  localparam int NUMWRDS    = 4;
  localparam int BITWRDS    = 2;
  localparam int NUMSROW    = 250;
  localparam int BITSROW    = 8;
  localparam int MEMWDTH    = NUMWRDS * WIDTH;  // One SRAM row
  localparam int SRAM_DELAY = 2;

  // Logical write request
  typedef struct packed {
    logic               valid;
    logic [BITADDR-1:0] adr;
    logic [WIDTH-1:0]   din;
    logic [WIDTH-1:0]   bw;   // Per-bit write enable
  } wr_req_t;

  // Logical read request
  typedef struct packed {
    logic               valid;
    logic [BITADDR-1:0] adr;
  } rd_req_t;

  // Row write to the wide SRAM
  typedef struct packed {
    logic               valid;
    logic [BITSROW-1:0] adr;
    logic [MEMWDTH-1:0] din;
    logic [MEMWDTH-1:0] bw;
  } mem_wr_t;

  // Row read to the wide SRAM
  typedef struct packed {
    logic               valid;
    logic [BITSROW-1:0] adr;
  } mem_rd_t;

endpackage

//--- logic/addr_split.sv
`timescale 1ns/10ps

module addr_split (
  input  logic [align_pkg::BITADDR-1:0] vaddr,
  output logic [align_pkg::BITSROW-1:0] vrow,
  output logic [align_pkg::BITWRDS-1:0] vword
);
  import align_pkg::*;

  generate
    if (NUMWRDS == (1 << BITWRDS)) begin : g_pow2
      assign vrow  = BITSROW'(vaddr >> BITWRDS);  // Plain bit slice
      assign vword = vaddr[BITWRDS-1:0];
    end else begin : g_np2
      assign vrow  = BITSROW'(vaddr / NUMWRDS);
      assign vword = BITWRDS'(vaddr % NUMWRDS);
    end
  endgenerate

  // Every legal logical address must land on an existing row
  always_comb begin
    if (vaddr < NUMADDR) begin
      assert (vrow < NUMSROW)
        else $error("addr_split row %0d out of range for address %0d", vrow, vaddr);
    end
  end

endmodule

//--- logic/write_align.sv
`timescale 1ns/10ps

module write_align (
  input  align_pkg::wr_req_t wr_req,
  output align_pkg::mem_wr_t mem_wr
);
  import align_pkg::*;

  logic [BITSROW-1:0] wr_row;
  logic [BITWRDS-1:0] wr_word;

  addr_split wr_split (
    .vaddr (wr_req.adr),
    .vrow  (wr_row),
    .vword (wr_word)
  );

  // Data goes to every lane, only the addressed lane gets mask bits
  always_comb begin
    mem_wr.valid = wr_req.valid;
    mem_wr.adr   = wr_row;
    for (int i = 0; i < NUMWRDS; i++) begin
      mem_wr.din[i*WIDTH +: WIDTH] = wr_req.din;
      if (wr_word == BITWRDS'(i)) begin
        mem_wr.bw[i*WIDTH +: WIDTH] = wr_req.bw;
      end else begin
        mem_wr.bw[i*WIDTH +: WIDTH] = '0;  // Neighbors untouched
      end
    end
  end

endmodule

//--- logic/read_align.sv
`timescale 1ns/10ps

module read_align (
  input  logic                         rd_clk,
  input  logic                         wr_rst,
  input  align_pkg::rd_req_t           rd_req,
  output align_pkg::mem_rd_t           mem_rd,
  input  logic [align_pkg::MEMWDTH-1:0] mem_rd_dout,
  output logic                         rd_vld,
  output logic [align_pkg::WIDTH-1:0]  rd_dout
);
  import align_pkg::*;

  logic [BITSROW-1:0]    rd_row;
  logic [BITWRDS-1:0]    rd_word;
  logic [SRAM_DELAY-1:0] pipe_vld;                // One bit per read in flight
  logic [BITWRDS-1:0]    pipe_word [SRAM_DELAY];
  logic [WIDTH-1:0]      lane_sel;

  addr_split rd_split (
    .vaddr (rd_req.adr),
    .vrow  (rd_row),
    .vword (rd_word)
  );

  always_comb begin
    mem_rd.valid = rd_req.valid;  // Row read issued right away
    mem_rd.adr   = rd_row;
  end

  always_ff @(posedge rd_clk) begin
    if (wr_rst) begin
      pipe_vld <= '0;
      rd_vld   <= 1'b0;
    end else begin
      pipe_vld <= SRAM_DELAY'({pipe_vld, rd_req.valid});
      rd_vld   <= pipe_vld[SRAM_DELAY-1];
    end
  end

  always_ff @(posedge rd_clk) begin
    pipe_word[0] <= rd_word;
    for (int i = 1; i < SRAM_DELAY; i++) begin
      pipe_word[i] <= pipe_word[i-1];
    end
  end

  // Lane of the returning row, lined up with the SRAM output
  assign lane_sel = mem_rd_dout[pipe_word[SRAM_DELAY-1]*WIDTH +: WIDTH];

  always_ff @(posedge rd_clk) begin
    if (pipe_vld[SRAM_DELAY-1]) begin
      rd_dout <= lane_sel;
    end
  end

  assert_rd_latency: assert property (@(posedge rd_clk) disable iff (wr_rst)
    rd_req.valid |-> ##(SRAM_DELAY+1) rd_vld);

  // No spurious results either
  assert_rd_no_extra: assert property (@(posedge rd_clk) disable iff (wr_rst)
    rd_vld |-> $past(rd_req.valid, SRAM_DELAY+1));

endmodule

//--- logic/sram_1r1w.sv
`timescale 1ns/10ps

module sram_1r1w (
  input  logic                          rd_clk,
  input  align_pkg::mem_wr_t            mem_wr,
  input  align_pkg::mem_rd_t            mem_rd,
  output logic [align_pkg::MEMWDTH-1:0] mem_rd_dout
);
  import align_pkg::*;

  logic [MEMWDTH-1:0] mem [NUMSROW];
  logic [MEMWDTH-1:0] rd_pipe [SRAM_DELAY];

  // Per-bit masked row write
  always_ff @(posedge rd_clk) begin
    if (mem_wr.valid) begin
      mem[mem_wr.adr] <= (mem_wr.din & mem_wr.bw) | (mem[mem_wr.adr] & ~mem_wr.bw);
    end
  end

  // Array is sampled before the same-edge write lands
  always_ff @(posedge rd_clk) begin
    if (mem_rd.valid) begin
      rd_pipe[0] <= mem[mem_rd.adr];
    end
    for (int i = 1; i < SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign mem_rd_dout = rd_pipe[SRAM_DELAY-1];

  assert_mem_wr_range: assert property (@(posedge rd_clk)
    mem_wr.valid |-> (mem_wr.adr < NUMSROW));

  assert_mem_rd_range: assert property (@(posedge rd_clk)
    mem_rd.valid |-> (mem_rd.adr < NUMSROW));

endmodule

//--- logic/align_checker.sv
`timescale 1ns/10ps

module align_checker (
  input  logic                          rd_clk,
  input  logic                          wr_rst,
  input  align_pkg::wr_req_t            wr_req,
  input  align_pkg::rd_req_t            rd_req,
  input  align_pkg::mem_wr_t            mem_wr,
  input  align_pkg::mem_rd_t            mem_rd,
  input  logic [align_pkg::MEMWDTH-1:0] mem_rd_dout,
  input  logic                          rd_vld,
  input  logic [align_pkg::WIDTH-1:0]   rd_dout,
  input  logic [align_pkg::BITADDR-1:0] select_addr
);
  import align_pkg::*;

  logic [BITSROW-1:0] sel_row;
  logic [BITWRDS-1:0] sel_word;
  logic [WIDTH-1:0]   row_din;
  logic [WIDTH-1:0]   row_bw;
  logic [WIDTH-1:0]   row_dout;
  logic               row_hit;
  logic               log_hit;
  logic [WIDTH-1:0]   row_known;   // Bits written since reset
  logic [WIDTH-1:0]   row_mem;
  logic [WIDTH-1:0]   log_known;
  logic [WIDTH-1:0]   log_mem;

  addr_split sel_split (
    .vaddr (select_addr),
    .vrow  (sel_row),
    .vword (sel_word)
  );

  // Shadowed lane as seen on the row interface
  assign row_din  = mem_wr.din[sel_word*WIDTH +: WIDTH];
  assign row_bw   = mem_wr.bw[sel_word*WIDTH +: WIDTH];
  assign row_dout = mem_rd_dout[sel_word*WIDTH +: WIDTH];
  assign row_hit  = mem_wr.valid && (mem_wr.adr == sel_row);
  assign log_hit  = wr_req.valid && (wr_req.adr == select_addr);

  always_ff @(posedge rd_clk) begin
    if (wr_rst) begin
      row_known <= '0;
      log_known <= '0;
    end else begin
      if (row_hit) row_known <= row_known | row_bw;
      if (log_hit) log_known <= log_known | wr_req.bw;
    end
  end

  always_ff @(posedge rd_clk) begin
    if (row_hit) row_mem <= (row_din & row_bw) | (row_mem & ~row_bw);
    if (log_hit) log_mem <= (wr_req.din & wr_req.bw) | (log_mem & ~wr_req.bw);
  end

  assume_wr_range: assume property (@(posedge rd_clk) disable iff (wr_rst)
    wr_req.valid |-> (wr_req.adr < NUMADDR));
  assume_rd_range: assume property (@(posedge rd_clk) disable iff (wr_rst)
    rd_req.valid |-> (rd_req.adr < NUMADDR));
  assume_sel_range: assume property (@(posedge rd_clk) select_addr < NUMADDR);

  // Row returned by the SRAM holds the shadow as of the read edge
  assert_mem_check: assert property (@(posedge rd_clk) disable iff (wr_rst)
    (mem_rd.valid && (mem_rd.adr == sel_row)) |-> ##SRAM_DELAY
    (($past(row_known, SRAM_DELAY) & row_dout) ==
     ($past(row_known, SRAM_DELAY) & $past(row_mem, SRAM_DELAY))));

  assert_dout_check: assert property (@(posedge rd_clk) disable iff (wr_rst)
    (rd_req.valid && (rd_req.adr == select_addr)) |-> ##(SRAM_DELAY+1)
    (rd_vld && (($past(log_known, SRAM_DELAY+1) & rd_dout) ==
                ($past(log_known, SRAM_DELAY+1) & $past(log_mem, SRAM_DELAY+1)))));

endmodule

//--- logic/align_ram_top.sv
`timescale 1ns/10ps

module align_ram_top (
  input  logic                          rd_clk,
  input  logic                          wr_rst,
  input  align_pkg::wr_req_t            wr_req,
  input  align_pkg::rd_req_t            rd_req,
  input  logic [align_pkg::BITADDR-1:0] select_addr,
  output logic                          rd_vld,
  output logic [align_pkg::WIDTH-1:0]   rd_dout
);
  import align_pkg::*;

  mem_wr_t            mem_wr;
  mem_rd_t            mem_rd;
  logic [MEMWDTH-1:0] mem_rd_dout;

  write_align write_align_i (
    .wr_req (wr_req),
    .mem_wr (mem_wr)
  );

  read_align read_align_i (
    .rd_clk      (rd_clk),
    .wr_rst      (wr_rst),
    .rd_req      (rd_req),
    .mem_rd      (mem_rd),
    .mem_rd_dout (mem_rd_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout)
  );

  sram_1r1w sram_1r1w_i (
    .rd_clk      (rd_clk),
    .mem_wr      (mem_wr),
    .mem_rd      (mem_rd),
    .mem_rd_dout (mem_rd_dout)
  );

  align_checker align_checker_i (
    .rd_clk      (rd_clk),
    .wr_rst      (wr_rst),
    .wr_req      (wr_req),
    .rd_req      (rd_req),
    .mem_wr      (mem_wr),
    .mem_rd      (mem_rd),
    .mem_rd_dout (mem_rd_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .select_addr (select_addr)
  );

endmodule

//--- test/align_ram_tb.sv
`timescale 1ns/10ps

module align_ram_tb;
  import align_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int DRIVE_DLY     = 2;
  localparam int RST_CYCLES    = 10;
  localparam int DRAIN_TIMEOUT = 50;
  localparam int B2B_CYCLES    = 200;
  localparam logic [BITADDR-1:0] SEL_ADDR = 10'd614;  // Row 153, lane 2

  logic               rd_clk;
  logic               wr_rst;
  wr_req_t            wr_req;
  rd_req_t            rd_req;
  logic [BITADDR-1:0] select_addr;
  logic               rd_vld;
  logic [WIDTH-1:0]   rd_dout;

  integer           seed;
  int               mismatches;
  int               other_errors;
  int               reads_issued;
  int               vld_count;
  logic [WIDTH-1:0] shadow [NUMADDR];  // Expected contents per logical address
  logic [WIDTH-1:0] exp_q [$];         // Expected rd_dout in issue order

  align_ram_top align_ram_top_i (
    .rd_clk      (rd_clk),
    .wr_rst      (wr_rst),
    .wr_req      (wr_req),
    .rd_req      (rd_req),
    .select_addr (select_addr),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout)
  );

  initial begin
    rd_clk = 1'b0;
    forever #(CLK_PERIOD/2) rd_clk = ~rd_clk;
  end

  // Each bit with bw set takes din and every other bit keeps its old value
  function automatic logic [WIDTH-1:0] merge_word(input logic [WIDTH-1:0] old_w,
                                                  input logic [WIDTH-1:0] din,
                                                  input logic [WIDTH-1:0] bw);
    logic [WIDTH-1:0] res;
    for (int b = 0; b < WIDTH; b++) begin
      if (bw[b]) begin
        res[b] = din[b];
      end else begin
        res[b] = old_w[b];
      end
    end
    return res;
  endfunction

  function automatic logic [WIDTH-1:0] expected_word(input logic [BITADDR-1:0] adr);
    return shadow[adr];
  endfunction

  function automatic logic [BITADDR-1:0] random_addr();
    int unsigned r;
    r = $unsigned($random(seed));
    return BITADDR'(r % NUMADDR);
  endfunction

  function automatic logic [WIDTH-1:0] random_word();
    return WIDTH'($random(seed));
  endfunction

  task automatic check_value(input string name, input logic [WIDTH-1:0] got,
                             input logic [WIDTH-1:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One drive cycle; the model reads before it applies the same-edge write
  task automatic issue_cycle(input logic do_wr, input logic [BITADDR-1:0] wadr,
                             input logic [WIDTH-1:0] wdin, input logic [WIDTH-1:0] wbw,
                             input logic do_rd, input logic [BITADDR-1:0] radr);
    wr_req.valid = do_wr;
    wr_req.adr   = wadr;
    wr_req.din   = wdin;
    wr_req.bw    = wbw;
    rd_req.valid = do_rd;
    rd_req.adr   = radr;
    if (do_rd) begin
      exp_q.push_back(expected_word(radr));
      reads_issued++;
    end
    if (do_wr) shadow[wadr] = merge_word(shadow[wadr], wdin, wbw);
    @(posedge rd_clk);
    #DRIVE_DLY;
    wr_req = '0;
    rd_req = '0;
  endtask

  task automatic write_word(input logic [BITADDR-1:0] adr, input logic [WIDTH-1:0] din,
                            input logic [WIDTH-1:0] bw);
    issue_cycle(1'b1, adr, din, bw, 1'b0, '0);
  endtask

  task automatic read_word(input logic [BITADDR-1:0] adr);
    issue_cycle(1'b0, '0, '0, '0, 1'b1, adr);
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge rd_clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Timeout at %0t: %0d read results did not arrive within %0d cycles",
               $time, exp_q.size(), DRAIN_TIMEOUT);
    end
    @(posedge rd_clk);
    #DRIVE_DLY;
  endtask

  // Outputs are stable at the falling edge
  always @(negedge rd_clk) begin
    if (wr_rst === 1'b0 && rd_vld === 1'b1) begin
      vld_count++;
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("Error at %0t: rd_vld went high with no read outstanding", $time);
      end else begin
        check_value("rd_dout", rd_dout, exp_q.pop_front());
      end
    end
  end

  initial begin : main_seq
    logic [BITADDR-1:0] adr;
    logic [BITADDR-1:0] adr_w;
    logic [WIDTH-1:0]   din;
    logic               do_w;
    int                 base;
    int                 reads_before;
    int                 vld_before;
    seed         = 32'hd64d;
    mismatches   = 0;
    other_errors = 0;
    reads_issued = 0;
    vld_count    = 0;
    wr_rst       = 1'b1;
    wr_req       = '0;
    rd_req       = '0;
    select_addr  = SEL_ADDR;
    for (int i = 0; i < RST_CYCLES; i++) begin
      @(posedge rd_clk);
      @(negedge rd_clk);
      check_value("rd_vld", {{(WIDTH-1){1'b0}}, rd_vld}, '0);
    end
    @(posedge rd_clk);
    #DRIVE_DLY;
    wr_rst = 1'b0;
    for (int i = 0; i < 5; i++) begin  // Quiet until the first read
      @(negedge rd_clk);
      check_value("rd_vld", {{(WIDTH-1){1'b0}}, rd_vld}, '0);
    end
    @(posedge rd_clk);
    #DRIVE_DLY;

    for (int a = 0; a < NUMADDR; a++) write_word(BITADDR'(a), random_word(), '1);
    for (int a = 0; a < NUMADDR; a++) read_word(BITADDR'(a));
    wait_drain();

    for (int n = 0; n < 24; n++) begin
      adr = (n % 4 == 0) ? SEL_ADDR : random_addr();
      write_word(adr, random_word(), random_word());
      base = (int'(adr) / NUMWRDS) * NUMWRDS;
      for (int i = 0; i < NUMWRDS; i++) read_word(BITADDR'(base + i));
    end
    wait_drain();

    reads_before = reads_issued;
    vld_before   = vld_count;
    for (int c = 0; c < B2B_CYCLES; c++) begin
      adr   = (c % 8 == 0) ? SEL_ADDR : random_addr();
      adr_w = (c % 8 == 4) ? SEL_ADDR : random_addr();
      do_w  = 1'($random(seed));
      issue_cycle(do_w, adr_w, random_word(), random_word(), 1'b1, adr);
    end
    wait_drain();
    check_value("rd_vld count", WIDTH'(vld_count - vld_before),
                WIDTH'(reads_issued - reads_before));

    for (int n = 0; n < 8; n++) begin
      adr = (n < 2) ? SEL_ADDR : random_addr();
      din = random_word();
      issue_cycle(1'b1, adr, din, '1, 1'b1, adr);  // Returns the old word
      read_word(adr);
    end
    wait_drain();

    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Error: %0d expected read results were never returned", exp_q.size());
    end
    $display("Errors: %0d mismatches, %0d other failures, %0d reads issued, %0d returned",
             mismatches, other_errors, reads_issued, vld_count);
    if (mismatches == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
logic/align_pkg.sv
logic/addr_split.sv
logic/write_align.sv
logic/read_align.sv
logic/sram_1r1w.sv
logic/align_checker.sv
logic/align_ram_top.sv
test/align_ram_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module align_ram_tb -f files.f -o align_ram_sim

sim_out=$(./obj_dir/align_ram_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
